// ==== src/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry
`define ICACHE_WAYS         2
`define ICACHE_SETS         16
`define ICACHE_LINE_WORDS   4    // words per line

// field widths
`define ICACHE_INDEX_BITS   4
`define ICACHE_OFFSET_BITS  2    // word offset inside a line
`define ICACHE_TAG_BITS     24

// address layout: tag 31:8, index 7:4, word offset 3:2, byte 1:0
`define ICACHE_OFFSET_LSB   2
`define ICACHE_INDEX_LSB    4
`define ICACHE_TAG_LSB      8

// round-robin pointer width, enough to name one way
`define ICACHE_WAY_PTR_BITS 1

`endif

// ==== src/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

  typedef logic [31:0]                       addr_t;     // byte address
  typedef logic [31:0]                       word_t;     // one instruction
  typedef logic [`ICACHE_TAG_BITS-1:0]       tag_t;
  typedef logic [`ICACHE_INDEX_BITS-1:0]     index_t;
  typedef logic [`ICACHE_OFFSET_BITS-1:0]    offset_t;
  typedef word_t [`ICACHE_LINE_WORDS-1:0]    line_t;     // word 0 in the low bits
  typedef logic [`ICACHE_WAYS-1:0]           way_mask_t; // one bit per way

  // fetch controller states
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    FILL_WRITE
  } ctrl_state_t;

  // lookup request, broadcast to all ways
  typedef struct packed {
    logic    valid;
    index_t  index;
    tag_t    tag;
    offset_t offset_1;   // word offset of slot 1
  } lookup_t;

  // line write into the victim way
  typedef struct packed {
    logic      we;
    index_t    index;
    tag_t      tag;
    line_t     line;
    way_mask_t way;      // one-hot victim
  } fill_t;

  // per-way answer to a lookup
  typedef struct packed {
    logic  hit;
    line_t line;
  } way_resp_t;

endpackage

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      cpu_req_1,
  input  logic      cpu_req_2,
  input  addr_t     instr_addr_1,
  input  addr_t     instr_addr_2,
  input  logic      hit,
  input  line_t     hit_line,
  input  way_mask_t victim,
  input  logic      refill_done,
  input  line_t     refill_line,
  output logic      cpu_addr_ok,
  output logic      cpu_data_ok,
  output logic      second_data_ok,
  output word_t     instr_rdata_1,
  output word_t     instr_rdata_2,
  output lookup_t   lookup,
  output fill_t     fill,
  output logic      refill_start,
  output addr_t     refill_addr
);

  ctrl_state_t state, state_next;

  addr_t   req_addr;      // accepted slot 1 address
  logic    pair_ok;       // slot 2 is the next word of the same line
  tag_t    req_tag;
  index_t  req_index;
  offset_t req_offset;
  offset_t next_offset;

  assign req_tag     = req_addr[31:`ICACHE_TAG_LSB];
  assign req_index   = req_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
  assign req_offset  = req_addr[`ICACHE_INDEX_LSB-1:`ICACHE_OFFSET_LSB];
  assign next_offset = req_offset + 1'b1;  // wraps at 3, second_data_ok low then

  always_ff @(posedge clk) begin
    if (reset)
      state <= IDLE;
    else
      state <= state_next;
  end

  // capture the request on acceptance
  always_ff @(posedge clk) begin
    if (cpu_addr_ok && cpu_req_1) begin
      req_addr <= instr_addr_1;
      pair_ok  <= cpu_req_2 &&
                  (instr_addr_2 == instr_addr_1 + 32'd4) &&
                  (instr_addr_1[`ICACHE_INDEX_LSB-1:`ICACHE_OFFSET_LSB] != '1);
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:       if (cpu_req_1) state_next = LOOKUP;
      LOOKUP:     state_next = hit ? IDLE : REFILL;
      REFILL:     if (refill_done) state_next = FILL_WRITE;
      FILL_WRITE: state_next = LOOKUP;  // look again, now hits
      default:    state_next = IDLE;
    endcase
  end

  assign cpu_addr_ok    = (state == IDLE);
  assign cpu_data_ok    = (state == LOOKUP) && hit;
  assign second_data_ok = cpu_data_ok && pair_ok;

  // word pick from the hitting line
  assign instr_rdata_1 = hit_line[req_offset];
  assign instr_rdata_2 = hit_line[next_offset];

  always_comb begin
    lookup.valid    = (state == LOOKUP);
    lookup.index    = req_index;
    lookup.tag      = req_tag;
    lookup.offset_1 = req_offset;
  end

  // one-cycle write of the refilled line into the victim
  always_comb begin
    fill.we    = (state == FILL_WRITE);
    fill.index = req_index;
    fill.tag   = req_tag;
    fill.line  = refill_line;   // held by the refill engine
    fill.way   = victim;
  end

  assign refill_start = (state == LOOKUP) && !hit;  // miss
  assign refill_addr  = {req_tag, req_index, {`ICACHE_INDEX_LSB{1'b0}}};  // line base

endmodule

// ==== src/icache_way.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way import icache_pkg::*; #(
  parameter int WAY_ID = 0   // bit position in the fill mask
) (
  input  logic      clk,
  input  logic      reset,
  input  lookup_t   lookup,
  input  fill_t     fill,
  output way_resp_t resp
);

  logic [`ICACHE_SETS-1:0] valid;               // one per set
  tag_t                    tags [`ICACHE_SETS];
  line_t                   data [`ICACHE_SETS];
  logic                    wr_en;

  // this way is the victim of the current fill
  assign wr_en = fill.we && fill.way[WAY_ID];

  always_ff @(posedge clk) begin
    if (reset)
      valid <= '0;                 // whole cache empty after reset
    else if (wr_en)
      valid[fill.index] <= 1'b1;
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags[fill.index] <= fill.tag;
      data[fill.index] <= fill.line;
    end
  end

  // compare against the broadcast lookup, same cycle
  always_comb begin
    resp.hit  = lookup.valid &&
                valid[lookup.index] &&
                (tags[lookup.index] == lookup.tag);
    resp.line = data[lookup.index];  // full line, word picked later
  end

endmodule

// ==== src/icache_hit_select.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_hit_select import icache_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  way_resp_t resp [`ICACHE_WAYS],
  input  lookup_t   lookup,
  input  fill_t     fill,
  output logic      hit,
  output line_t     hit_line,
  output way_mask_t victim
);

  localparam logic [`ICACHE_WAY_PTR_BITS-1:0] LAST_WAY = `ICACHE_WAY_PTR_BITS'(`ICACHE_WAYS - 1);

  way_mask_t                      hits;
  logic [`ICACHE_WAY_PTR_BITS-1:0] rr_ptr [`ICACHE_SETS];  // next victim per set

  // gather hits, take the line of the hitting way
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hits[w] = resp[w].hit;
      if (resp[w].hit)
        hit_line = resp[w].line;  // at most one way hits
    end
  end

  assign hit = lookup.valid && (|hits);

  // round robin, one pointer per set
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        rr_ptr[s] <= '0;          // way 0 first
    end else if (fill.we) begin
      if (rr_ptr[fill.index] == LAST_WAY)
        rr_ptr[fill.index] <= '0;
      else
        rr_ptr[fill.index] <= rr_ptr[fill.index] + 1'b1;
    end
  end

  // one-hot victim for the set being looked up
  assign victim = way_mask_t'(1) << rr_ptr[lookup.index];

endmodule

// ==== src/icache_refill.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill import icache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  refill_start,
  input  addr_t refill_addr,
  input  logic  mem_addr_ok,
  input  logic  mem_data_ok,
  input  word_t mem_read_data,
  output logic  mem_req,
  output addr_t mem_read_addr,
  output logic  refill_done,
  output line_t refill_line
);

  localparam offset_t LAST_WORD = offset_t'(`ICACHE_LINE_WORDS - 1);

  addr_t   base;          // line base address
  offset_t word_cnt;      // word being fetched
  logic    busy;          // refill in progress
  logic    outstanding;   // read accepted, data not back yet
  line_t   line_buf;

  // request held until addr_ok, then wait for the data
  assign mem_req       = busy && !outstanding;
  assign mem_read_addr = {base[31:`ICACHE_INDEX_LSB], word_cnt, 2'b00};
  assign refill_line   = line_buf;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      outstanding <= 1'b0;
      word_cnt    <= '0;
      refill_done <= 1'b0;
    end else begin
      refill_done <= 1'b0;          // pulse
      if (refill_start && !busy) begin
        busy        <= 1'b1;
        outstanding <= 1'b0;
        word_cnt    <= '0;          // ascending from the base
      end else if (busy) begin
        if (mem_req && mem_addr_ok)
          outstanding <= 1'b1;
        if (outstanding && mem_data_ok) begin
          outstanding <= 1'b0;
          word_cnt    <= word_cnt + 1'b1;
          if (word_cnt == LAST_WORD) begin
            busy        <= 1'b0;
            refill_done <= 1'b1;    // line complete
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refill_start && !busy)
      base <= refill_addr;
  end

  // drop each returned word into its slot
  always_ff @(posedge clk) begin
    if (busy && outstanding && mem_data_ok)
      line_buf[word_cnt] <= mem_read_data;
  end

endmodule

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
  input  logic  clk,
  input  logic  reset,

  // cpu fetch side, two slots
  input  logic  cpu_req_1,
  input  logic  cpu_req_2,
  input  addr_t instr_addr_1,
  input  addr_t instr_addr_2,
  output logic  cpu_addr_ok,
  output logic  cpu_data_ok,
  output logic  second_data_ok,
  output word_t instr_rdata_1,
  output word_t instr_rdata_2,

  // sram-like read channel
  output logic  mem_req,
  output addr_t mem_read_addr,
  input  word_t mem_read_data,
  input  logic  mem_addr_ok,
  input  logic  mem_data_ok
);

  lookup_t   lookup;
  fill_t     fill;
  way_resp_t way_resp [`ICACHE_WAYS];
  logic      hit;
  line_t     hit_line;
  way_mask_t victim;
  logic      refill_start;
  addr_t     refill_addr;
  logic      refill_done;
  line_t     refill_line;

  icache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cpu_req_1      (cpu_req_1),
    .cpu_req_2      (cpu_req_2),
    .instr_addr_1   (instr_addr_1),
    .instr_addr_2   (instr_addr_2),
    .hit            (hit),
    .hit_line       (hit_line),
    .victim         (victim),
    .refill_done    (refill_done),
    .refill_line    (refill_line),
    .cpu_addr_ok    (cpu_addr_ok),
    .cpu_data_ok    (cpu_data_ok),
    .second_data_ok (second_data_ok),
    .instr_rdata_1  (instr_rdata_1),
    .instr_rdata_2  (instr_rdata_2),
    .lookup         (lookup),
    .fill           (fill),
    .refill_start   (refill_start),
    .refill_addr    (refill_addr)
  );

  // identical ways, each answers the same lookup
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_way #(.WAY_ID(w)) u_way (
      .clk    (clk),
      .reset  (reset),
      .lookup (lookup),
      .fill   (fill),
      .resp   (way_resp[w])
    );
  end

  icache_hit_select u_hit_select (
    .clk      (clk),
    .reset    (reset),
    .resp     (way_resp),
    .lookup   (lookup),
    .fill     (fill),
    .hit      (hit),
    .hit_line (hit_line),
    .victim   (victim)
  );

  icache_refill u_refill (
    .clk           (clk),
    .reset         (reset),
    .refill_start  (refill_start),
    .refill_addr   (refill_addr),
    .mem_addr_ok   (mem_addr_ok),
    .mem_data_ok   (mem_data_ok),
    .mem_read_data (mem_read_data),
    .mem_req       (mem_req),
    .mem_read_addr (mem_read_addr),
    .refill_done   (refill_done),
    .refill_line   (refill_line)
  );

endmodule

// ==== bench/sram_like_mem.sv ====
`timescale 1ns/1ps

module sram_like_mem import icache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall_en,       // random addr_ok gaps and data delays
  input  logic  mem_req,
  input  addr_t mem_read_addr,
  output logic  mem_addr_ok,
  output logic  mem_data_ok,
  output word_t mem_read_data
);

  logic [31:0] lcg;
  logic        ready;           // addr_ok gate for this cycle
  logic        busy;            // one read in flight
  logic [1:0]  delay;           // cycles left before data_ok
  addr_t       held_addr;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign mem_addr_ok = ready && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      lcg           <= 32'h0efb_6b57;
      ready         <= 1'b1;
      busy          <= 1'b0;
      delay         <= '0;
      mem_data_ok   <= 1'b0;
      mem_read_data <= '0;
    end else begin
      lcg         <= lcg_step(lcg);
      ready       <= !stall_en || (lcg[22:21] != 2'b00);  // about 1 stall in 4
      mem_data_ok <= 1'b0;
      if (mem_req && mem_addr_ok) begin
        busy      <= 1'b1;
        held_addr <= mem_read_addr;
        delay     <= stall_en ? lcg[27:26] : 2'd0;
      end else if (busy) begin
        if (delay == 2'd0) begin
          busy          <= 1'b0;
          mem_data_ok   <= 1'b1;
          mem_read_data <= {held_addr[31:2], 2'b00} ^ 32'h5a5a_0000;  // word rule
        end else begin
          delay <= delay - 1'b1;
        end
      end
    end
  end

endmodule

// ==== bench/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

  localparam int RESET_CYCLES   = 10;
  localparam int RAND_FETCHES   = 40;
  localparam int FIXED_FETCHES  = 20;
  localparam int FETCH_MAX      = 60;   // worst miss with stalls plus margin
  localparam int TIMEOUT_CYCLES = (RAND_FETCHES + FIXED_FETCHES) * FETCH_MAX + 200;

  logic  clk, reset, cpu_req_1, cpu_req_2, stall_en;
  addr_t instr_addr_1, instr_addr_2, mem_read_addr;
  logic  cpu_addr_ok, cpu_data_ok, second_data_ok;
  word_t instr_rdata_1, instr_rdata_2, mem_read_data;
  logic  mem_req, mem_addr_ok, mem_data_ok;

  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          req_cycles;          // mem_req high cycles in the current fetch
  addr_t       read_addrs[$];       // accepted memory reads in the current fetch
  logic [31:0] rand_state;
  word_t       got_rd1, got_rd2;
  logic        got_sec;
  int          got_lat;             // edges from acceptance to cpu_data_ok

  icache_top UUT (.*);

  sram_like_mem u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // memory side monitor
  always @(posedge clk) begin
    if (mem_req) req_cycles++;
    if (mem_req && mem_addr_ok) read_addrs.push_back(mem_read_addr);
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: no response from the cache within %0d cycles", TIMEOUT_CYCLES);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t word_rule(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_0000;  // what the memory holds
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  // a miss reads the line base plus 0, 4, 8, 12 in order
  task automatic check_refill_reads(input addr_t a);
    check_value("mem read count", read_addrs.size(), 4);
    if (read_addrs.size() == 4) begin
      for (int i = 0; i < 4; i++)
        check_value("mem_read_addr", read_addrs[i], {a[31:4], 4'h0} + 4 * i);
    end
  endtask

  task automatic fetch_pair(input addr_t a1, input logic r2, input addr_t a2);
    @(posedge clk);
    // idle between fetches and right after reset
    check_value("cpu_addr_ok", cpu_addr_ok, 1);
    check_value("cpu_data_ok", cpu_data_ok, 0);
    check_value("second_data_ok", second_data_ok, 0);
    check_value("mem_req", mem_req, 0);
    read_addrs.delete();
    req_cycles = 0;
    cpu_req_1    <= 1'b1;
    cpu_req_2    <= r2;
    instr_addr_1 <= a1;
    instr_addr_2 <= a2;
    @(posedge clk);
    while (!cpu_addr_ok) @(posedge clk);   // accepted at this edge
    cpu_req_1 <= 1'b0;
    cpu_req_2 <= 1'b0;
    got_lat = 0;
    do begin
      @(posedge clk);
      got_lat++;
      check_value("cpu_addr_ok", cpu_addr_ok, 0);  // busy until the data returns
    end while (!cpu_data_ok);
    got_rd1 = instr_rdata_1;
    got_rd2 = instr_rdata_2;
    got_sec = second_data_ok;
  endtask

  task automatic test_cold_miss();
    fetch_pair(32'h0000_1234, 1'b0, 32'h0);
    check_refill_reads(32'h0000_1234);
    check_value("instr_rdata_1", got_rd1, word_rule(32'h0000_1234));
  endtask

  task automatic test_hit();
    fetch_pair(32'h0000_1238, 1'b0, 32'h0);  // same line as the cold miss
    check_value("hit latency", got_lat, 1);
    check_value("mem_req cycles", req_cycles, 0);
    check_value("instr_rdata_1", got_rd1, word_rule(32'h0000_1238));
  endtask

  task automatic test_dual_fetch();
    addr_t a1;
    for (int off = 0; off < 4; off++) begin
      a1 = 32'h0000_2040 + 4 * off;
      fetch_pair(a1, 1'b1, a1 + 4);
      check_value("second_data_ok", got_sec, off != 3);  // offset 3 crosses the line
      check_value("instr_rdata_1", got_rd1, word_rule(a1));
      if (off != 3) check_value("instr_rdata_2", got_rd2, word_rule(a1 + 4));
    end
    fetch_pair(32'h0000_2040, 1'b0, 32'h0000_2044);  // slot 2 idle
    check_value("second_data_ok", got_sec, 0);
    check_value("instr_rdata_1", got_rd1, word_rule(32'h0000_2040));
  endtask

  task automatic test_replacement();
    addr_t t0 = 32'h0010_0050;   // three tags in index 5
    addr_t t1 = 32'h0020_0050;
    addr_t t2 = 32'h0030_0050;
    fetch_pair(t0, 1'b0, 32'h0);
    check_refill_reads(t0);
    fetch_pair(t1, 1'b0, 32'h0);
    check_refill_reads(t1);
    fetch_pair(t2, 1'b0, 32'h0);  // victim is way 0 which holds t0
    check_refill_reads(t2);
    fetch_pair(t0, 1'b0, 32'h0);
    check_refill_reads(t0);       // evicted so refilled again
    check_value("instr_rdata_1", got_rd1, word_rule(t0));
    fetch_pair(t2, 1'b0, 32'h0);
    check_value("hit latency", got_lat, 1);
    check_value("mem_req cycles", req_cycles, 0);
    check_value("instr_rdata_1", got_rd1, word_rule(t2));
  endtask

  task automatic test_back_pressure();
    addr_t a1;
    logic  r2;
    stall_en <= 1'b1;
    repeat (RAND_FETCHES) begin
      rand_state = lcg_step(rand_state);
      a1 = {20'h0, rand_state[27:18], 2'b00};  // 4 KB window gives hits and misses
      r2 = rand_state[31];
      fetch_pair(a1, r2, a1 + 4);
      if (read_addrs.size() != 0) check_refill_reads(a1);
      check_value("second_data_ok", got_sec, r2 && (a1[3:2] != 2'b11));
      check_value("instr_rdata_1", got_rd1, word_rule(a1));
      if (r2 && a1[3:2] != 2'b11) check_value("instr_rdata_2", got_rd2, word_rule(a1 + 4));
    end
    stall_en <= 1'b0;
  endtask

  task automatic test_reset_mid_run();
    fetch_pair(32'h0000_1234, 1'b0, 32'h0);  // make sure it is cached
    fetch_pair(32'h0000_1234, 1'b0, 32'h0);
    check_value("hit latency", got_lat, 1);
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    fetch_pair(32'h0000_1234, 1'b0, 32'h0);  // valid bits cleared so miss again
    check_refill_reads(32'h0000_1234);
    check_value("instr_rdata_1", got_rd1, word_rule(32'h0000_1234));
  endtask

  initial begin
    reset        = 1'b1;
    cpu_req_1    = 1'b0;
    cpu_req_2    = 1'b0;
    instr_addr_1 = '0;
    instr_addr_2 = '0;
    stall_en     = 1'b0;
    rand_state   = 32'h0efb_6b57;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    test_cold_miss();
    test_hit();
    test_dual_fetch();
    test_replacement();
    test_back_pressure();
    test_reset_mid_run();
    @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_way.sv
src/icache_hit_select.sv
src/icache_refill.sv
src/icache_top.sv
bench/sram_like_mem.sv
bench/tb_icache.sv
